/* list.f */
+incdir+verification
rtl/csr_pkg.sv
rtl/csr_access_unit.sv
rtl/csr_trap_regs.sv
rtl/csr_perf_counters.sv
rtl/csr_file_top.sv
verification/csr_file_tb.sv

/* rtl/csr_access_unit.sv */
// front end of the CSR port: merges block read responses into the read data
// and turns the access into one write request with resolved write data
`default_nettype none

module csr_access_unit (
  input  logic                                csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
  input  csr_pkg::csr_op_e                    csr_op_i,
  input  logic [csr_pkg::CSR_W-1:0]           csr_wdata_i,
  input  csr_pkg::csr_rsp_t                   trap_rsp_i,
  input  csr_pkg::csr_rsp_t                   perf_rsp_i,
  output logic [csr_pkg::CSR_W-1:0]           csr_rdata_o,
  output csr_pkg::csr_req_t                   csr_req_o
);

  // current value of the addressed register
  logic [csr_pkg::CSR_W-1:0] old_val;

  // read merge, unmapped reads give zero
  always_comb begin
    if (trap_rsp_i.hit) begin
      old_val = trap_rsp_i.rdata;
    end else if (perf_rsp_i.hit) begin
      old_val = perf_rsp_i.rdata;
    end else begin
      old_val = '0;
    end
  end

  assign csr_rdata_o = old_val;

  ////////////////////////////////////////
  // operation rule, same for every CSR
  ////////////////////////////////////////
  always_comb begin
    csr_req_o.we   = csr_access_i && (csr_op_i != csr_pkg::CSR_OP_NONE);
    // blocks match the address themselves
    csr_req_o.addr = csr_addr_i;
    case (csr_op_i)
      csr_pkg::CSR_OP_WRITE: csr_req_o.wdata = csr_wdata_i;
      csr_pkg::CSR_OP_SET:   csr_req_o.wdata = csr_wdata_i | old_val;
      csr_pkg::CSR_OP_CLEAR: csr_req_o.wdata = old_val & ~csr_wdata_i;
      // none, data unused since we stays low
      default:               csr_req_o.wdata = csr_wdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/csr_file_top.sv */
// machine-mode CSR file top level: access port, trap registers and counters
// reads are combinational, writes land on the next rising edge
`default_nettype none

module csr_file_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // CSR access port
  input  logic                           csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  input  logic [csr_pkg::CSR_W-1:0]      csr_wdata_i,
  output logic [csr_pkg::CSR_W-1:0]      csr_rdata_o,
  // trap interface
  input  csr_pkg::trap_ctrl_t            trap_i,
  input  logic [csr_pkg::CSR_W-1:0]      pc_if_i,
  input  logic [csr_pkg::CSR_W-1:0]      pc_id_i,
  output logic [csr_pkg::CSR_W-1:0]      epc_o,
  output logic                           m_irq_enable_o,
  // static core info
  input  logic [23:0]                    boot_addr_i,
  input  logic [3:0]                     core_id_i,
  input  logic [5:0]                     cluster_id_i,
  // raw events for the counters
  input  csr_pkg::perf_events_t          events_i
);

  csr_pkg::csr_req_t csr_req;
  csr_pkg::csr_rsp_t trap_rsp;
  csr_pkg::csr_rsp_t perf_rsp;

  ////////////////////////////////////////
  // access port
  ////////////////////////////////////////
  csr_access_unit u_access (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_rsp_i   (trap_rsp),
    .perf_rsp_i   (perf_rsp),
    .csr_rdata_o  (csr_rdata_o),
    .csr_req_o    (csr_req)
  );

  // machine trap registers
  csr_trap_regs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr_i),
    .csr_req_i      (csr_req),
    .trap_i         (trap_i),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .boot_addr_i    (boot_addr_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .rsp_o          (trap_rsp),
    .epc_o          (epc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  // counter bank
  csr_perf_counters u_perf (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_addr_i (csr_addr_i),
    .csr_req_i  (csr_req),
    .events_i   (events_i),
    .rsp_o      (perf_rsp)
  );

endmodule

`default_nettype wire

/* rtl/csr_perf_counters.sv */
// performance counter bank with PCER event mask and PCMR mode register
// events are registered one cycle before the counter adds them
`default_nettype none

module csr_perf_counters (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_req_t              csr_req_i,
  input  csr_pkg::perf_events_t          events_i,
  output csr_pkg::csr_rsp_t              rsp_o
);

  localparam int N = csr_pkg::N_PERF_EVT;
  localparam int HI = csr_pkg::CSR_ADDR_W - 1;
  localparam int LO = csr_pkg::PERF_IDX_W;

  logic                              id_valid_q;
  logic [N-1:0]                      evt;
  logic [N-1:0]                      inc;
  logic [N-1:0]                      inc_q;
  logic [N-1:0][csr_pkg::CSR_W-1:0]  cnt_q;
  logic [N-1:0][csr_pkg::CSR_W-1:0]  cnt_d;
  logic [N-1:0]                      pcer_q;
  logic [N-1:0]                      pcer_d;
  logic [1:0]                        pcmr_q;
  logic [1:0]                        pcmr_d;
  logic [csr_pkg::PERF_IDX_W-1:0]    rd_idx;
  logic [csr_pkg::PERF_IDX_W-1:0]    wr_idx;
  logic                              rd_is_pccr;
  logic                              wr_is_pccr;
  logic                              wr_all;
  logic                              rd_hit;
  logic [csr_pkg::CSR_W-1:0]         rd_data;

  ////////////////////////////////////////
  // event qualification
  ////////////////////////////////////////
  // cycles
  assign evt[0]  = 1'b1;
  // retired instructions
  assign evt[1]  = events_i.id_valid & events_i.is_decoding;
  // hazards are counted once the stalled instruction leaves id
  assign evt[2]  = events_i.ld_stall & id_valid_q;
  assign evt[3]  = events_i.jr_stall & id_valid_q;
  // fetch wait, jumps and branches excluded
  assign evt[4]  = events_i.imiss & ~events_i.pc_set;
  assign evt[5]  = events_i.mem_load;
  assign evt[6]  = events_i.mem_store;
  assign evt[7]  = events_i.jump & id_valid_q;
  assign evt[8]  = events_i.branch & id_valid_q;
  assign evt[9]  = events_i.branch & events_i.branch_taken & id_valid_q;
  // compressed instructions
  assign evt[10] = events_i.id_valid & events_i.is_decoding & events_i.is_compressed;

  // per-event mask and global enable
  assign inc = evt & pcer_q & {N{pcmr_q[0]}};

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////
  assign rd_idx     = csr_addr_i[LO-1:0];
  assign rd_is_pccr = (csr_addr_i[HI:LO] == csr_pkg::ADDR_PCCR_BASE[HI:LO]);

  always_comb begin
    rd_hit  = 1'b0;
    rd_data = '0;
    if (rd_is_pccr) begin
      rd_hit = 1'b1;
      // unused slots and the broadcast slot read zero
      if (rd_idx < N) begin
        rd_data = cnt_q[rd_idx];
      end
    end else if (csr_addr_i == csr_pkg::ADDR_PCER) begin
      rd_hit       = 1'b1;
      rd_data[N-1:0] = pcer_q;
    end else if (csr_addr_i == csr_pkg::ADDR_PCMR) begin
      rd_hit       = 1'b1;
      rd_data[1:0] = pcmr_q;
    end
  end

  assign rsp_o.hit   = rd_hit;
  assign rsp_o.rdata = rd_data;

  ////////////////////////////////////////
  // write and count
  ////////////////////////////////////////
  assign wr_idx     = csr_req_i.addr[LO-1:0];
  assign wr_is_pccr = csr_req_i.we &&
                      (csr_req_i.addr[HI:LO] == csr_pkg::ADDR_PCCR_BASE[HI:LO]);
  assign wr_all     = (csr_req_i.addr == csr_pkg::ADDR_PCCR_ALL);

  always_comb begin
    for (int i = 0; i < N; i++) begin
      cnt_d[i] = cnt_q[i];
      // hold at all ones when saturating, otherwise wrap
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // software write beats the pending increment
      if (wr_is_pccr && (wr_all || (wr_idx == csr_pkg::PERF_IDX_W'(i)))) begin
        cnt_d[i] = csr_req_i.wdata;
      end
    end
  end

  // mask and mode registers
  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (csr_req_i.we && (csr_req_i.addr == csr_pkg::ADDR_PCER)) begin
      pcer_d = csr_req_i.wdata[N-1:0];
    end
    if (csr_req_i.we && (csr_req_i.addr == csr_pkg::ADDR_PCMR)) begin
      pcmr_d = csr_req_i.wdata[1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      cnt_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= csr_pkg::PCMR_RESET;
    end else begin
      id_valid_q <= events_i.id_valid;
      inc_q      <= inc;
      cnt_q      <= cnt_d;
      pcer_q     <= pcer_d;
      pcmr_q     <= pcmr_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
// shared widths, CSR map, access operations and bus structs for the CSR file
// every RTL block refers to these by scoped name
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int CSR_W      = 32;
  localparam int CSR_ADDR_W = 12;
  // top bit flags an interrupt
  localparam int CAUSE_W    = 6;
  localparam int N_PERF_EVT = 11;
  localparam int PERF_IDX_W = 5;

  ////////////////////////////////////////
  // machine CSR addresses
  ////////////////////////////////////////
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MISA      = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;
  // counter window 0x780..0x79F, top slot writes all counters
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_BASE = 12'h780;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_ALL  = 12'h79F;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCER      = 12'h7A0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCMR      = 12'h7A1;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  // two-bit MPP, hardwired to machine mode
  localparam int MSTATUS_MPP_LSB  = 11;

  // global enable plus saturate
  localparam logic [1:0] PCMR_RESET = 2'd3;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  // write request, data already resolved for set and clear
  typedef struct packed {
    logic                  we;
    logic [CSR_ADDR_W-1:0] addr;
    logic [CSR_W-1:0]      wdata;
  } csr_req_t;

  // read response of one register block
  typedef struct packed {
    logic             hit;
    logic [CSR_W-1:0] rdata;
  } csr_rsp_t;

  // trap controls from the core controller
  typedef struct packed {
    logic               save_cause;
    logic               save_if;
    logic               save_id;
    logic               mret;
    logic [CAUSE_W-1:0] cause;
  } trap_ctrl_t;

  // raw core events feeding the counters
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

endpackage

`default_nettype wire

/* rtl/csr_trap_regs.sv */
// machine trap registers mstatus, mepc and mcause plus the read-only machine CSRs
// trap entry and mret take priority over a CSR write in the same cycle
`default_nettype none

module csr_trap_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_req_t              csr_req_i,
  input  csr_pkg::trap_ctrl_t            trap_i,
  input  logic [csr_pkg::CSR_W-1:0]      pc_if_i,
  input  logic [csr_pkg::CSR_W-1:0]      pc_id_i,
  input  logic [23:0]                    boot_addr_i,
  input  logic [3:0]                     core_id_i,
  input  logic [5:0]                     cluster_id_i,
  output csr_pkg::csr_rsp_t              rsp_o,
  output logic [csr_pkg::CSR_W-1:0]      epc_o,
  output logic                           m_irq_enable_o
);

  // only the two interrupt enables are stored since MPP is constant
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  mstatus_t                          mstatus_q;
  mstatus_t                          mstatus_d;
  logic [csr_pkg::CSR_W-1:0]         mepc_q;
  logic [csr_pkg::CSR_W-1:0]         mepc_d;
  logic [csr_pkg::CAUSE_W-1:0]       mcause_q;
  logic [csr_pkg::CAUSE_W-1:0]       mcause_d;
  logic [csr_pkg::CSR_W-1:0]         exc_pc;
  logic                              rd_hit;
  logic [csr_pkg::CSR_W-1:0]         rd_data;

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (csr_addr_i)
      csr_pkg::ADDR_MSTATUS: begin
        rd_data[csr_pkg::MSTATUS_MIE_BIT]       = mstatus_q.mie;
        rd_data[csr_pkg::MSTATUS_MPIE_BIT]      = mstatus_q.mpie;
        // machine mode only
        rd_data[csr_pkg::MSTATUS_MPP_LSB +: 2]  = 2'b11;
      end
      // no extensions advertised
      csr_pkg::ADDR_MISA: rd_data = '0;
      // trap vector follows the boot address
      csr_pkg::ADDR_MTVEC: rd_data = {boot_addr_i, 8'h00};
      csr_pkg::ADDR_MEPC: rd_data = mepc_q;
      csr_pkg::ADDR_MCAUSE: begin
        // irq flag in the msb and code in the low bits
        rd_data[csr_pkg::CSR_W-1]           = mcause_q[csr_pkg::CAUSE_W-1];
        rd_data[csr_pkg::CAUSE_W-2:0]       = mcause_q[csr_pkg::CAUSE_W-2:0];
      end
      csr_pkg::ADDR_MHARTID: rd_data = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default: rd_hit = 1'b0;
    endcase
  end

  assign rsp_o.hit   = rd_hit;
  assign rsp_o.rdata = rd_data;

  // saved pc comes from the if stage, otherwise from the id stage
  assign exc_pc = trap_i.save_if ? pc_if_i : pc_id_i;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////
  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // software writes
    if (csr_req_i.we) begin
      case (csr_req_i.addr)
        csr_pkg::ADDR_MSTATUS: begin
          mstatus_d.mie  = csr_req_i.wdata[csr_pkg::MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_req_i.wdata[csr_pkg::MSTATUS_MPIE_BIT];
        end
        csr_pkg::ADDR_MEPC: mepc_d = csr_req_i.wdata;
        // same bit layout as the read so set and clear round-trip
        csr_pkg::ADDR_MCAUSE: begin
          mcause_d = {csr_req_i.wdata[csr_pkg::CSR_W-1],
                      csr_req_i.wdata[csr_pkg::CAUSE_W-2:0]};
        end
        default: ;
      endcase
    end

    // trap controller overrides the write
    if (trap_i.save_cause) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = exc_pc;
      mcause_d       = trap_i.cause;
    end else if (trap_i.mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  // exported state
  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

`default_nettype wire

/* verification/csr_ref_model.svh */
// expected-value model of the CSR file, shadow registers plus reference functions
// included inside the testbench module and stepped once per rising clock edge
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// shadow state
logic        m_mie;
logic        m_mpie;
logic [31:0] m_mepc;
// irq flag in bit 5
logic [5:0]  m_mcause;
logic [10:0] m_pcer;
logic [1:0]  m_pcmr;
logic [31:0] m_cnt [0:10];
// increments seen last cycle, added on this edge
logic [10:0] m_inc_q;
logic        m_idv_q;

function automatic void model_reset();
  int i;
  m_mie    = 1'b0;
  m_mpie   = 1'b0;
  m_mepc   = '0;
  m_mcause = '0;
  m_pcer   = '0;
  m_pcmr   = csr_pkg::PCMR_RESET;
  m_inc_q  = '0;
  m_idv_q  = 1'b0;
  for (i = 0; i < csr_pkg::N_PERF_EVT; i++) begin
    m_cnt[i] = '0;
  end
endfunction

// write, set and clear, same for every register
function automatic logic [31:0] apply_op(input csr_pkg::csr_op_e op,
                                         input logic [31:0] old_val,
                                         input logic [31:0] wdata);
  case (op)
    csr_pkg::CSR_OP_SET:   return old_val | wdata;
    csr_pkg::CSR_OP_CLEAR: return old_val & ~wdata;
    default:               return wdata;
  endcase
endfunction

function automatic logic [31:0] model_read(input logic [11:0] addr);
  logic [31:0] r;
  int          idx;
  r = '0;
  idx = int'(addr) - int'(csr_pkg::ADDR_PCCR_BASE);
  if (addr == csr_pkg::ADDR_MSTATUS) begin
    r[csr_pkg::MSTATUS_MIE_BIT]  = m_mie;
    r[csr_pkg::MSTATUS_MPIE_BIT] = m_mpie;
    r[csr_pkg::MSTATUS_MPP_LSB +: 2] = 2'b11;
  end else if (addr == csr_pkg::ADDR_MTVEC) begin
    r = {boot_addr, 8'h00};
  end else if (addr == csr_pkg::ADDR_MEPC) begin
    r = m_mepc;
  end else if (addr == csr_pkg::ADDR_MCAUSE) begin
    r[31]  = m_mcause[5];
    r[4:0] = m_mcause[4:0];
  end else if (addr == csr_pkg::ADDR_MHARTID) begin
    r[10:5] = cluster_id;
    r[3:0]  = core_id;
  end else if (addr == csr_pkg::ADDR_PCER) begin
    r[10:0] = m_pcer;
  end else if (addr == csr_pkg::ADDR_PCMR) begin
    r[1:0] = m_pcmr;
  end else if (idx >= 0 && idx < csr_pkg::N_PERF_EVT) begin
    r = m_cnt[idx];
  end
  // misa, 0x79F, empty counter slots and unmapped all stay zero
  return r;
endfunction

function automatic void trap_entry(input csr_pkg::trap_ctrl_t tr, input logic [31:0] pc_if,
                                   input logic [31:0] pc_id, input logic old_mie);
  m_mpie   = old_mie;
  m_mie    = 1'b0;
  m_mepc   = tr.save_if ? pc_if : pc_id;
  m_mcause = tr.cause;
endfunction

function automatic void mret_step(input logic old_mpie);
  m_mie  = old_mpie;
  m_mpie = 1'b1;
endfunction

// one counter step, holds at all ones only while saturating
function automatic logic [31:0] counter_step(input logic [31:0] cnt, input logic inc,
                                             input logic sat);
  if (!inc || (sat && cnt == 32'hFFFF_FFFF)) begin
    return cnt;
  end
  return cnt + 32'd1;
endfunction

function automatic logic [10:0] qualify_events(input csr_pkg::perf_events_t ev,
                                               input logic idv_q);
  logic [10:0] e;
  e[0]  = 1'b1;
  e[1]  = ev.id_valid & ev.is_decoding;
  e[2]  = ev.ld_stall & idv_q;
  e[3]  = ev.jr_stall & idv_q;
  e[4]  = ev.imiss & ~ev.pc_set;
  e[5]  = ev.mem_load;
  e[6]  = ev.mem_store;
  e[7]  = ev.jump & idv_q;
  e[8]  = ev.branch & idv_q;
  e[9]  = ev.branch & ev.branch_taken & idv_q;
  e[10] = ev.id_valid & ev.is_decoding & ev.is_compressed;
  return e;
endfunction

// advance the shadow state by one rising edge
function automatic void model_clock(input logic acc, input logic [11:0] addr,
                                    input csr_pkg::csr_op_e op, input logic [31:0] wdata,
                                    input csr_pkg::trap_ctrl_t tr, input logic [31:0] pc_if,
                                    input logic [31:0] pc_id, input csr_pkg::perf_events_t ev);
  logic [31:0] res;
  logic        we;
  logic        old_mie;
  logic        old_mpie;
  logic [10:0] inc;
  int          i;
  res      = apply_op(op, model_read(addr), wdata);
  we       = acc && (op != csr_pkg::CSR_OP_NONE);
  old_mie  = m_mie;
  old_mpie = m_mpie;
  inc      = qualify_events(ev, m_idv_q) & m_pcer & {11{m_pcmr[0]}};
  for (i = 0; i < csr_pkg::N_PERF_EVT; i++) begin
    m_cnt[i] = counter_step(m_cnt[i], m_inc_q[i], m_pcmr[1]);
    // software write beats the pending increment
    if (we && (addr == csr_pkg::ADDR_PCCR_ALL || int'(addr) == csr_pkg::ADDR_PCCR_BASE + i)) begin
      m_cnt[i] = res;
    end
  end
  if (we) begin
    case (addr)
      csr_pkg::ADDR_MSTATUS: begin
        m_mie  = res[csr_pkg::MSTATUS_MIE_BIT];
        m_mpie = res[csr_pkg::MSTATUS_MPIE_BIT];
      end
      csr_pkg::ADDR_MEPC:   m_mepc = res;
      csr_pkg::ADDR_MCAUSE: m_mcause = {res[31], res[4:0]};
      csr_pkg::ADDR_PCER:   m_pcer = res[10:0];
      csr_pkg::ADDR_PCMR:   m_pcmr = res[1:0];
      default: ;
    endcase
  end
  // trap and mret override a write to the same fields
  if (tr.save_cause) begin
    trap_entry(tr, pc_if, pc_id, old_mie);
  end else if (tr.mret) begin
    mret_step(old_mpie);
  end
  m_inc_q = inc;
  m_idv_q = ev.id_valid;
endfunction

`endif

/* verification/csr_file_tb.sv */
// testbench for the machine CSR file, random and directed accesses, traps and counters
// every access is checked against the reference model on the rising edge
`default_nettype none

module csr_file_tb;

  logic                  clk;
  logic                  rst_n;
  logic                  csr_access;
  logic [11:0]           csr_addr;
  csr_pkg::csr_op_e      csr_op;
  logic [31:0]           csr_wdata;
  csr_pkg::trap_ctrl_t   trap;
  logic [31:0]           pc_if;
  logic [31:0]           pc_id;
  logic [23:0]           boot_addr;
  logic [3:0]            core_id;
  logic [5:0]            cluster_id;
  csr_pkg::perf_events_t events;
  logic [31:0]           csr_rdata;
  logic [31:0]           epc;
  logic                  m_irq_enable;
  logic [31:0]           last_rdata;
  logic [31:0]           hold_val;

  `include "csr_ref_model.svh"

  csr_file_top uut (
    .clk (clk), .rst_n (rst_n),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata),
    .trap_i (trap), .pc_if_i (pc_if), .pc_id_i (pc_id),
    .epc_o (epc), .m_irq_enable_o (m_irq_enable),
    .boot_addr_i (boot_addr), .core_id_i (core_id), .cluster_id_i (cluster_id),
    .events_i (events)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////
  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic mismatch_error(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
    stop_on_failure();
  endtask

  task automatic timeout_error(input string what);
    $display("Timed out at time %0t while waiting for %s", $time, what);
    stop_on_failure();
  endtask

  // comparing process steps the model after the checks
  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      if (csr_access) begin
        assert (csr_rdata == model_read(csr_addr))
          else mismatch_error($sformatf("read of %h", csr_addr), csr_rdata, model_read(csr_addr));
      end
      assert (epc == m_mepc) else mismatch_error("epc_o", epc, m_mepc);
      assert (m_irq_enable == m_mie) else mismatch_error("m_irq_enable_o", m_irq_enable, m_mie);
      model_clock(csr_access, csr_addr, csr_op, csr_wdata, trap, pc_if, pc_id, events);
    end
  end

  ////////////////////////////////////////
  // stimulus helpers called on a falling edge
  ////////////////////////////////////////
  // one-cycle access with read data captured at the rising edge
  task automatic do_access(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wdata);
    csr_access = 1'b1;
    csr_op     = op;
    csr_addr   = addr;
    csr_wdata  = wdata;
    @(posedge clk);
    last_rdata = csr_rdata;
    @(negedge clk);
    csr_access = 1'b0;
    csr_op     = csr_pkg::CSR_OP_NONE;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // read counter idx until it equals target or differs when want_equal is 0
  task automatic poll_counter(input int idx, input logic [31:0] target, input logic want_equal);
    int tries;
    tries = 0;
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE + 12'(idx), '0);
    while ((last_rdata == target) != want_equal) begin
      if (tries == 40) timeout_error($sformatf("counter %0d to reach %h", idx, target));
      tries++;
      do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE + 12'(idx), '0);
    end
  endtask

  function automatic logic [11:0] pick_rw_addr();
    case ($urandom_range(4, 0))
      0:       return csr_pkg::ADDR_MSTATUS;
      1:       return csr_pkg::ADDR_MEPC;
      2:       return csr_pkg::ADDR_MCAUSE;
      3:       return csr_pkg::ADDR_PCER;
      default: return csr_pkg::ADDR_PCMR;
    endcase
  endfunction

  initial begin
    void'($urandom(18552));
    rst_n      = 1'b0;
    csr_access = 1'b0;
    csr_addr   = '0;
    csr_op     = csr_pkg::CSR_OP_NONE;
    csr_wdata  = '0;
    trap       = '0;
    pc_if      = '0;
    pc_id      = '0;
    events     = '0;
    last_rdata = '0;
    boot_addr  = 24'($urandom());
    core_id    = 4'($urandom());
    cluster_id = 6'($urandom());
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // constant registers and unmapped space
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_MTVEC, '0);
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_MHARTID, '0);
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_MISA, $urandom());
    for (int n = 0; n < 16; n++) begin
      do_access(csr_pkg::CSR_OP_NONE, 12'($urandom()), '0);
    end

    // random read-modify-write traffic with random events
    for (int n = 0; n < 300; n++) begin
      events = 12'($urandom());
      do_access(csr_pkg::csr_op_e'(2'($urandom())), pick_rw_addr(), $urandom());
      do_access(csr_pkg::CSR_OP_NONE, pick_rw_addr(), '0);
    end
    events = '0;

    // trap entry from if then id racing an mstatus write and then mret
    for (int k = 0; k < 2; k++) begin
      do_access(csr_pkg::CSR_OP_SET, csr_pkg::ADDR_MSTATUS, 32'h8);
      pc_if           = $urandom();
      pc_id           = $urandom();
      trap.save_cause = 1'b1;
      trap.save_if    = (k == 0);
      trap.save_id    = (k != 0);
      trap.cause      = 6'($urandom());
      do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_MSTATUS, 32'h88);
      trap = '0;
      assert (m_irq_enable == 1'b0) else mismatch_error("irq enable after trap", m_irq_enable, 0);
      assert (epc == (k == 0 ? pc_if : pc_id))
        else mismatch_error("epc_o after trap", epc, (k == 0 ? pc_if : pc_id));
      do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_MCAUSE, '0);
      do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_MSTATUS, '0);
      trap.mret = 1'b1;
      idle_cycles(1);
      trap = '0;
      assert (m_irq_enable == 1'b1) else mismatch_error("irq enable after mret", m_irq_enable, 1);
    end

    // constant events, masked counters and global enable
    events = '{id_valid: 1'b1, is_decoding: 1'b1, is_compressed: 1'b1, imiss: 1'b1,
               pc_set: 1'b0, jump: 1'b1, branch: 1'b1, branch_taken: 1'b0,
               ld_stall: 1'b1, jr_stall: 1'b0, mem_load: 1'b1, mem_store: 1'b0};
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCMR, 32'd3);
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h5A7);
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCCR_ALL, '0);
    idle_cycles(7);
    for (int i = 0; i < 12; i++) begin
      do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE + 12'(i), '0);
    end
    do_access(csr_pkg::CSR_OP_CLEAR, csr_pkg::ADDR_PCMR, 32'd1);
    idle_cycles(3);
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE, '0);
    hold_val = m_cnt[0];
    idle_cycles(6);
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE, '0);
    assert (last_rdata == hold_val)
      else mismatch_error("counter 0 while disabled", last_rdata, hold_val);

    // saturation and then wrap once saturate is cleared
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCMR, 32'd3);
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCCR_BASE, 32'hFFFF_FFFE);
    poll_counter(0, 32'hFFFF_FFFF, 1'b1);
    idle_cycles(5);
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE, '0);
    assert (last_rdata == 32'hFFFF_FFFF)
      else mismatch_error("saturated counter 0", last_rdata, 32'hFFFF_FFFF);
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCMR, 32'd1);
    poll_counter(0, 32'hFFFF_FFFF, 1'b0);
    assert (last_rdata == 32'd0) else mismatch_error("wrapped counter 0", last_rdata, 32'd0);

    // broadcast load of all counters
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, $urandom());
    do_access(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCCR_ALL, $urandom());
    for (int i = 0; i < 12; i++) begin
      do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_BASE + 12'(i), '0);
    end
    do_access(csr_pkg::CSR_OP_NONE, csr_pkg::ADDR_PCCR_ALL, '0);
    idle_cycles(2);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
